//--- hdl/dma_bus_control.sv
// External bus control outputs of the DMA controller
//   hold request, address enable and address strobe
//   per-channel acknowledge with selectable polarity
//   memory and I/O read/write strobes by transfer type
`include "dma_defs.svh"

module dma_bus_control (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      master_clear_i,
    input  dma_pkg::cycle_state_e     next_state_i,
    input  logic [`DMA_CHANNELS-1:0]  grant_i,
    input  dma_pkg::channel_mode_t    active_mode_i,
    input  logic                      dack_active_high_i,
    output logic                      hold_request_o,
    output logic                      address_enable_o,
    output logic                      address_strobe_o,
    output logic [`DMA_CHANNELS-1:0]  dack_o,
    output dma_pkg::bus_strobes_t     strobes_o
);
    import dma_pkg::*;

    logic                     is_cascade;
    logic                     in_service;
    logic                     ack_window;
    logic                     read_window;
    logic                     write_window;
    logic [`DMA_CHANNELS-1:0] ack_lines;
    bus_strobes_t             strobes_next;

    assign is_cascade = (active_mode_i.xfer_mode == MODE_CASCADE);

    // S1 through S4
    assign in_service = next_state_i inside {ST_S1, ST_S2, ST_S3, ST_WAIT, ST_S4};

    // Cascade only acknowledges in S4
    assign ack_window = is_cascade ? (next_state_i == ST_S4)
                                   : (next_state_i inside {ST_S2, ST_S3, ST_WAIT, ST_S4});

    assign read_window  = next_state_i inside {ST_S3, ST_WAIT};
    assign write_window = (next_state_i == ST_WAIT);

    assign ack_lines = ack_window ? grant_i : '0;

    // Write moves I/O to memory, read moves memory to I/O, verify moves nothing
    always_comb begin
        strobes_next              = `DMA_STROBES_RESET;
        strobes_next.io_read      = read_window  && (active_mode_i.xfer_type == TYPE_WRITE);
        strobes_next.memory_write = write_window && (active_mode_i.xfer_type == TYPE_WRITE);
        strobes_next.memory_read  = read_window  && (active_mode_i.xfer_type == TYPE_READ);
        strobes_next.io_write     = write_window && (active_mode_i.xfer_type == TYPE_READ);
    end

    // ========================================================================
    // Output registers
    // ========================================================================
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            hold_request_o   <= `DMA_CTRL_RESET;
            address_enable_o <= `DMA_CTRL_RESET;
            address_strobe_o <= `DMA_CTRL_RESET;
            dack_o           <= `DMA_DACK_RESET;
            strobes_o        <= `DMA_STROBES_RESET;
        end else if (master_clear_i) begin
            hold_request_o   <= `DMA_CTRL_RESET;
            address_enable_o <= `DMA_CTRL_RESET;
            address_strobe_o <= `DMA_CTRL_RESET;
            dack_o           <= `DMA_DACK_RESET;
            strobes_o        <= `DMA_STROBES_RESET;
        end else begin
            hold_request_o   <= (next_state_i != ST_IDLE);
            address_enable_o <= in_service && !is_cascade;
            address_strobe_o <= (next_state_i == ST_S1) && !is_cascade;
            dack_o           <= dack_active_high_i ? ack_lines : ~ack_lines;
            strobes_o        <= strobes_next;
        end
    end

endmodule

//--- hdl/dma_cycle_fsm.sv
// Service sequencer of the DMA controller
//   fixed priority selection, lowest channel wins
//   service state machine from idle through S4
//   granted channel latch and next word pulse
`include "dma_defs.svh"

module dma_cycle_fsm (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      master_clear_i,
    input  logic [`DMA_CHANNELS-1:0]  request_i,
    input  logic                      hold_acknowledge_i,
    input  logic                      ready_i,
    input  dma_pkg::channel_mode_t    active_mode_i,
    input  logic                      transfer_end_i,
    output dma_pkg::cycle_state_e     state_o,
    output dma_pkg::cycle_state_e     next_state_o,
    output logic [`DMA_CHANNELS-1:0]  grant_o,
    output logic                      next_word_o
);
    import dma_pkg::*;

    logic [`DMA_CHANNELS-1:0] priority_pick;
    logic                     granted_request;
    logic                     is_cascade;

    // Lowest numbered request wins
    always_comb begin
        priority_pick = '0;
        for (int i = `DMA_CHANNELS - 1; i >= 0; i--) begin
            if (request_i[i])
                priority_pick = `DMA_CHANNELS'(1) << i;
        end
    end

    assign granted_request = |(request_i & grant_o);
    assign is_cascade      = (active_mode_i.xfer_mode == MODE_CASCADE);

    // ========================================================================
    // Next state
    // ========================================================================
    always_comb begin
        next_state_o = state_o;
        case (state_o)
            ST_IDLE:      if (|request_i) next_state_o = ST_HOLD_WAIT;
            ST_HOLD_WAIT: if (hold_acknowledge_i) next_state_o = ST_S1;
            ST_S1:        next_state_o = is_cascade ? ST_S4 : ST_S2;
            ST_S2:        next_state_o = ST_S3;
            ST_S3:        next_state_o = ST_WAIT;
            ST_WAIT:      if (ready_i) next_state_o = ST_S4;
            ST_S4: begin
                case (active_mode_i.xfer_mode)
                    MODE_CASCADE: if (!granted_request) next_state_o = ST_IDLE;
                    MODE_SINGLE:  next_state_o = ST_IDLE;
                    MODE_DEMAND: begin
                        if (!granted_request || transfer_end_i)
                            next_state_o = ST_IDLE;
                        else
                            next_state_o = ST_S2;
                    end
                    default:      next_state_o = transfer_end_i ? ST_IDLE : ST_S2;
                endcase
            end
            default:      next_state_o = ST_IDLE;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state_o     <= ST_IDLE;
            grant_o     <= '0;
            next_word_o <= 1'b0;
        end else if (master_clear_i) begin
            state_o     <= ST_IDLE;
            grant_o     <= '0;
            next_word_o <= 1'b0;
        end else begin
            state_o <= next_state_o;
            // Grant follows the requests only while idle
            if (state_o == ST_IDLE)
                grant_o <= priority_pick;
            // One pulse per transferred word
            next_word_o <= (next_state_o == ST_S4) && !is_cascade;
        end
    end

endmodule

//--- hdl/dma_defs.svh
// Shared sizing macros for the DMA timing and control block
//   channel count and CPU data width
//   reset values of the external control outputs
`ifndef DMA_DEFS_SVH
`define DMA_DEFS_SVH

// Channel count is fixed by the mode register layout
`define DMA_CHANNELS 4

// CPU data bus width
`define DMA_DATA_W 8

// Reset values of the external outputs
`define DMA_CTRL_RESET 1'b0
`define DMA_STROBES_RESET 4'b0000
// Acknowledge defaults to active low, so all lines idle high
`define DMA_DACK_RESET {`DMA_CHANNELS{1'b1}}

`endif

//--- hdl/dma_end_of_process.sv
// End of process handling of the DMA controller
//   external end-of-process latch
//   terminal count and transfer end
//   sticky terminal count status, cleared after a status read
`include "dma_defs.svh"

module dma_end_of_process (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      master_clear_i,
    input  dma_pkg::cycle_state_e     state_i,
    input  logic [`DMA_CHANNELS-1:0]  grant_i,
    input  logic                      next_word_i,
    input  logic                      underflow_i,
    input  logic                      end_of_process_i,
    input  logic                      read_status_i,
    output logic                      transfer_end_o,
    output logic                      end_of_process_o,
    output logic [`DMA_CHANNELS-1:0]  tc_status_o
);
    import dma_pkg::*;

    logic external_eop;
    logic read_status_q;
    logic status_read_done;

    // Sampled from S1 up to the wait state, dropped once idle
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            external_eop <= 1'b0;
        end else if (master_clear_i || (state_i == ST_IDLE)) begin
            external_eop <= 1'b0;
        end else if (end_of_process_i && (state_i inside {ST_S1, ST_S2, ST_S3, ST_WAIT})) begin
            external_eop <= 1'b1;
        end
    end

    // Terminal count comes from the external word counter
    assign end_of_process_o = next_word_i && underflow_i;
    assign transfer_end_o   = next_word_i && (underflow_i || external_eop);

    // ========================================================================
    // Status bits
    // ========================================================================
    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            read_status_q <= 1'b0;
        else
            read_status_q <= read_status_i;
    end

    assign status_read_done = read_status_q && !read_status_i;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            tc_status_o <= '0;
        end else if (master_clear_i || status_read_done) begin
            tc_status_o <= '0;
        end else if (transfer_end_o) begin
            tc_status_o <= tc_status_o | grant_i;
        end
    end

endmodule

//--- hdl/dma_mode_registers.sv
// Command and mode registers of the DMA controller
//   acknowledge polarity bit from the command word
//   four channel mode entries written by channel number
//   mode lookup for the granted channel
`include "dma_defs.svh"

module dma_mode_registers (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      master_clear_i,
    input  logic                      write_command_i,
    input  logic                      write_mode_i,
    input  dma_pkg::cpu_word_u        cpu_data_i,
    input  logic [`DMA_CHANNELS-1:0]  grant_i,
    output dma_pkg::channel_mode_t    active_mode_o,
    output logic                      dack_active_high_o
);
    import dma_pkg::*;

    channel_mode_t [`DMA_CHANNELS-1:0] channel_modes;

    // ========================================================================
    // Command register
    // ========================================================================
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            dack_active_high_o <= 1'b0;
        end else if (master_clear_i) begin
            dack_active_high_o <= 1'b0;
        end else if (write_command_i) begin
            dack_active_high_o <= cpu_data_i.command.dack_active_high;
        end
    end

    // ========================================================================
    // Mode registers
    // ========================================================================
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            channel_modes <= '0;
        end else if (master_clear_i) begin
            channel_modes <= '0;
        end else if (write_mode_i) begin
            for (int i = 0; i < `DMA_CHANNELS; i++) begin
                if (cpu_data_i.mode.channel == 2'(i)) begin
                    channel_modes[i].xfer_mode <= cpu_data_i.mode.xfer_mode;
                    // Cascade channels move no data
                    if (cpu_data_i.mode.xfer_mode == MODE_CASCADE)
                        channel_modes[i].xfer_type <= TYPE_NONE;
                    else
                        channel_modes[i].xfer_type <= cpu_data_i.mode.xfer_type;
                end
            end
        end
    end

    // Granted channel entry, grant is one-hot
    always_comb begin
        active_mode_o = '0;
        for (int i = 0; i < `DMA_CHANNELS; i++) begin
            if (grant_i[i])
                active_mode_o = channel_modes[i];
        end
    end

endmodule

//--- hdl/dma_pkg.sv
// Types shared by the DMA timing and control blocks
//   transfer type and transfer mode encodings
//   command and mode word layouts, CPU word union
//   per-channel mode, bus strobe set, service state encoding
`include "dma_defs.svh"

package dma_pkg;

    typedef enum logic [1:0] {
        TYPE_VERIFY = 2'b00,
        TYPE_WRITE  = 2'b01,
        TYPE_READ   = 2'b10,
        TYPE_NONE   = 2'b11
    } transfer_type_e;

    typedef enum logic [1:0] {
        MODE_DEMAND  = 2'b00,
        MODE_SINGLE  = 2'b01,
        MODE_BLOCK   = 2'b10,
        MODE_CASCADE = 2'b11
    } transfer_mode_e;

    // Mode write, top bit first
    typedef struct packed {
        transfer_mode_e xfer_mode;
        logic           decrement;
        logic           autoinit;
        transfer_type_e xfer_type;
        logic [1:0]     channel;
    } mode_word_t;

    // Command write, only the acknowledge polarity is kept
    typedef struct packed {
        logic                      dack_active_high;
        logic [`DMA_DATA_W-2:0]    reserved;
    } command_word_t;

    typedef union packed {
        mode_word_t    mode;
        command_word_t command;
    } cpu_word_u;

    typedef struct packed {
        transfer_type_e xfer_type;
        transfer_mode_e xfer_mode;
    } channel_mode_t;

    typedef struct packed {
        logic memory_read;
        logic memory_write;
        logic io_read;
        logic io_write;
    } bus_strobes_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_HOLD_WAIT,
        ST_S1,
        ST_S2,
        ST_S3,
        ST_WAIT,
        ST_S4
    } cycle_state_e;

endpackage

//--- hdl/dma_timing_control.sv
// Timing and control section of a four-channel DMA controller
//   mode registers, service sequencer, bus control outputs
//   and end-of-process logic wired together
`include "dma_defs.svh"

module dma_timing_control (
    input  logic                      clock,
    input  logic                      reset,
    input  dma_pkg::cpu_word_u        cpu_data_i,
    input  logic                      write_command_i,
    input  logic                      write_mode_i,
    input  logic                      master_clear_i,
    input  logic                      read_status_i,
    input  logic [`DMA_CHANNELS-1:0]  request_i,
    input  logic                      hold_acknowledge_i,
    input  logic                      ready_i,
    input  logic                      underflow_i,
    input  logic                      end_of_process_i,
    output logic                      hold_request_o,
    output logic                      address_enable_o,
    output logic                      address_strobe_o,
    output logic [`DMA_CHANNELS-1:0]  dack_o,
    output dma_pkg::bus_strobes_t     strobes_o,
    output logic                      next_word_o,
    output logic                      end_of_process_o,
    output logic [`DMA_CHANNELS-1:0]  tc_status_o
);
    import dma_pkg::*;

    cycle_state_e             cycle_state;
    cycle_state_e             next_state;
    logic [`DMA_CHANNELS-1:0] grant;
    channel_mode_t            active_mode;
    logic                     dack_active_high;
    logic                     transfer_end;

    dma_mode_registers u_mode_registers (
        .clock              (clock),
        .reset              (reset),
        .master_clear_i     (master_clear_i),
        .write_command_i    (write_command_i),
        .write_mode_i       (write_mode_i),
        .cpu_data_i         (cpu_data_i),
        .grant_i            (grant),
        .active_mode_o      (active_mode),
        .dack_active_high_o (dack_active_high)
    );

    dma_cycle_fsm u_cycle_fsm (
        .clock              (clock),
        .reset              (reset),
        .master_clear_i     (master_clear_i),
        .request_i          (request_i),
        .hold_acknowledge_i (hold_acknowledge_i),
        .ready_i            (ready_i),
        .active_mode_i      (active_mode),
        .transfer_end_i     (transfer_end),
        .state_o            (cycle_state),
        .next_state_o       (next_state),
        .grant_o            (grant),
        .next_word_o        (next_word_o)
    );

    dma_bus_control u_bus_control (
        .clock              (clock),
        .reset              (reset),
        .master_clear_i     (master_clear_i),
        .next_state_i       (next_state),
        .grant_i            (grant),
        .active_mode_i      (active_mode),
        .dack_active_high_i (dack_active_high),
        .hold_request_o     (hold_request_o),
        .address_enable_o   (address_enable_o),
        .address_strobe_o   (address_strobe_o),
        .dack_o             (dack_o),
        .strobes_o          (strobes_o)
    );

    dma_end_of_process u_end_of_process (
        .clock              (clock),
        .reset              (reset),
        .master_clear_i     (master_clear_i),
        .state_i            (cycle_state),
        .grant_i            (grant),
        .next_word_i        (next_word_o),
        .underflow_i        (underflow_i),
        .end_of_process_i   (end_of_process_i),
        .read_status_i      (read_status_i),
        .transfer_end_o     (transfer_end),
        .end_of_process_o   (end_of_process_o),
        .tc_status_o        (tc_status_o)
    );

endmodule

//--- test/dma_timing_control_chk.sv
// Bound protocol checks for the DMA timing and control block
//   address strobe only inside address enable
//   bus strobes and next word only under hold request
//   memory read and memory write never together
//   failure count read by the testbench
module dma_timing_control_chk (
    input logic                  clock,
    input logic                  reset,
    input logic                  hold_request_o,
    input logic                  address_enable_o,
    input logic                  address_strobe_o,
    input dma_pkg::bus_strobes_t strobes_o,
    input logic                  next_word_o
);

    int failures = 0;

    strobe_inside_enable: assert property (
        @(posedge clock) disable iff (reset) address_strobe_o |-> address_enable_o)
        else begin
            failures++;
            $error("address strobe seen without address enable");
        end

    // Bus strobes only while the bus is ours
    strobes_need_hold: assert property (
        @(posedge clock) disable iff (reset) (|strobes_o) |-> hold_request_o)
        else begin
            failures++;
            $error("bus strobe seen without hold request");
        end

    no_memory_read_write: assert property (
        @(posedge clock) disable iff (reset)
        !(strobes_o.memory_read && strobes_o.memory_write))
        else begin
            failures++;
            $error("memory read and memory write active together");
        end

    next_word_needs_hold: assert property (
        @(posedge clock) disable iff (reset) next_word_o |-> hold_request_o)
        else begin
            failures++;
            $error("next word pulse seen without hold request");
        end

endmodule

bind dma_timing_control dma_timing_control_chk u_chk (.*);

//--- test/dma_timing_control_tb.sv
// Testbench for the DMA timing and control block
//   clock, reset, hold acknowledge and ready peripheral model
//   word counter model driving underflow
//   reference function for strobes, acknowledge and address outputs
//   directed transfers in single, block, demand and cascade mode
`include "dma_defs.svh"

module dma_timing_control_tb;
    import dma_pkg::*;

    localparam int WAIT_LIMIT = 200;

    typedef struct packed {
        bus_strobes_t             strobes;
        logic [`DMA_CHANNELS-1:0] dack;
        logic                     address_enable;
        logic                     address_strobe;
    } expected_t;

    logic                     clock;
    logic                     reset;
    cpu_word_u                cpu_data_i;
    logic                     write_command_i;
    logic                     write_mode_i;
    logic                     master_clear_i;
    logic                     read_status_i;
    logic [`DMA_CHANNELS-1:0] request_i;
    logic                     hold_acknowledge_i;
    logic                     ready_i;
    logic                     underflow_i;
    logic                     end_of_process_i;
    logic                     hold_request_o;
    logic                     address_enable_o;
    logic                     address_strobe_o;
    logic [`DMA_CHANNELS-1:0] dack_o;
    bus_strobes_t             strobes_o;
    logic                     next_word_o;
    logic                     end_of_process_o;
    logic [`DMA_CHANNELS-1:0] tc_status_o;

    // Programmed state as the testbench sees it
    mode_word_t    mode_words [`DMA_CHANNELS];
    command_word_t command_word;
    int            expected_channel;
    expected_t     now_expected;

    logic [31:0] lcg_state;
    int          hold_delay;
    int          word_limit;
    int          words_seen;
    int          eop_seen;
    int          checks;
    int          errors;
    int          timeouts;

    dma_timing_control UUT (.*);

    always #2 clock = ~clock;

    function automatic logic [31:0] lcg_next(input logic [31:0] value);
        return value * 32'd1664525 + 32'd1013904223;
    endfunction

    // ========================================================================
    // Reference model of the outputs for one service state
    // ========================================================================
    function automatic expected_t expected_outputs(input mode_word_t mode,
                                                   input command_word_t command,
                                                   input cycle_state_e state);
        expected_t                result;
        logic                     cascade;
        logic                     span;
        logic                     ack;
        logic                     read_phase;
        logic                     write_phase;
        logic [`DMA_CHANNELS-1:0] lines;
        cascade = (mode.xfer_mode == MODE_CASCADE);
        // S2 through S4
        span = (state == ST_S2) || (state == ST_S3) || (state == ST_WAIT) || (state == ST_S4);
        ack = cascade ? (state == ST_S4) : span;
        lines = ack ? (`DMA_CHANNELS'(1) << mode.channel) : '0;
        read_phase = !cascade && ((state == ST_S3) || (state == ST_WAIT));
        write_phase = !cascade && (state == ST_WAIT);
        result.strobes.io_read = read_phase && (mode.xfer_type == TYPE_WRITE);
        result.strobes.memory_write = write_phase && (mode.xfer_type == TYPE_WRITE);
        result.strobes.memory_read = read_phase && (mode.xfer_type == TYPE_READ);
        result.strobes.io_write = write_phase && (mode.xfer_type == TYPE_READ);
        result.dack = command.dack_active_high ? lines : ~lines;
        result.address_enable = !cascade && ((state == ST_S1) || span);
        result.address_strobe = !cascade && (state == ST_S1);
        return result;
    endfunction

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] want);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, want);
        end
    endtask

    // Compare the bus outputs while the controller owns the bus
    always @(posedge clock) begin
        if (!reset && hold_request_o) begin
            now_expected = expected_outputs(mode_words[expected_channel], command_word,
                                            UUT.cycle_state);
            check_value("strobes_o", strobes_o, now_expected.strobes);
            check_value("dack_o", dack_o, now_expected.dack);
            check_value("address_enable_o", address_enable_o, now_expected.address_enable);
            check_value("address_strobe_o", address_strobe_o, now_expected.address_strobe);
        end
    end

    // ========================================================================
    // Peripheral and word counter models
    // ========================================================================
    always @(negedge clock) begin
        lcg_state = lcg_next(lcg_state);
        ready_i <= lcg_state[31];
        // Hold acknowledge follows hold request after one to three cycles
        if (!hold_request_o) begin
            hold_acknowledge_i <= 1'b0;
            hold_delay <= 1 + int'(lcg_state[30:29]) % 3;
        end else if (hold_delay > 1) begin
            hold_delay <= hold_delay - 1;
        end else begin
            hold_acknowledge_i <= 1'b1;
        end
    end

    // Underflow stays high through the last word, a limit of zero never ends
    always @(negedge clock) begin
        if (next_word_o)
            words_seen <= words_seen + 1;
        if (end_of_process_o)
            eop_seen <= eop_seen + 1;
        if (!next_word_o)
            underflow_i <= (word_limit != 0) && (words_seen >= word_limit - 1);
    end

    function automatic logic watched(input string name);
        if (name == "hold_request_o")
            return hold_request_o;
        if (name == "dack_o[0]")
            return dack_o[0];
        return 1'bx;
    endfunction

    task automatic wait_signal(input string name, input logic level);
        int cycles;
        cycles = 0;
        while (watched(name) !== level && cycles < WAIT_LIMIT) begin
            @(negedge clock);
            cycles++;
        end
        if (watched(name) !== level) begin
            timeouts++;
            $display("Timeout at %0t: %s never became %b", $time, name, level);
        end
    endtask

    task automatic wait_words(input int count);
        int cycles;
        cycles = 0;
        while (words_seen < count && cycles < WAIT_LIMIT) begin
            @(negedge clock);
            cycles++;
        end
        if (words_seen < count) begin
            timeouts++;
            $display("Timeout at %0t: only %0d of %0d words moved", $time, words_seen, count);
        end
    endtask

    task automatic write_mode(input transfer_mode_e xfer_mode, input transfer_type_e xfer_type,
                              input int channel);
        mode_word_t word;
        word = '0;
        word.xfer_mode = xfer_mode;
        word.xfer_type = xfer_type;
        word.channel = channel[1:0];
        mode_words[channel] <= word;
        cpu_data_i.mode <= word;
        write_mode_i <= 1'b1;
        @(negedge clock);
        write_mode_i <= 1'b0;
    endtask

    task automatic write_command(input logic active_high);
        command_word_t word;
        word = '0;
        word.dack_active_high = active_high;
        command_word <= word;
        cpu_data_i.command <= word;
        write_command_i <= 1'b1;
        @(negedge clock);
        write_command_i <= 1'b0;
    endtask

    // Request one channel, release it once the expected words are done
    task automatic run_transfer(input int channel, input int words, input int limit);
        expected_channel <= channel;
        word_limit <= limit;
        words_seen <= 0;
        eop_seen <= 0;
        request_i[channel] <= 1'b1;
        @(negedge clock);
        wait_words(words);
        request_i[channel] <= 1'b0;
        wait_signal("hold_request_o", 1'b0);
        @(negedge clock);
        check_value("next_word_o pulses", words_seen, words);
    endtask

    task automatic check_idle_outputs(input logic [`DMA_CHANNELS-1:0] dack_idle);
        check_value("hold_request_o", hold_request_o, 0);
        check_value("address_enable_o", address_enable_o, 0);
        check_value("address_strobe_o", address_strobe_o, 0);
        check_value("strobes_o", strobes_o, 0);
        check_value("next_word_o", next_word_o, 0);
        check_value("end_of_process_o", end_of_process_o, 0);
        check_value("tc_status_o", tc_status_o, 0);
        check_value("dack_o", dack_o, dack_idle);
    endtask

    // ========================================================================
    // Stimulus
    // ========================================================================
    initial begin
        clock = 1'b0;
        reset = 1'b1;
        cpu_data_i = '0;
        write_command_i = 1'b0;
        write_mode_i = 1'b0;
        master_clear_i = 1'b0;
        read_status_i = 1'b0;
        request_i = '0;
        hold_acknowledge_i = 1'b0;
        ready_i = 1'b0;
        underflow_i = 1'b0;
        end_of_process_i = 1'b0;
        for (int i = 0; i < `DMA_CHANNELS; i++)
            mode_words[i] = '0;
        command_word = '0;
        expected_channel = 0;
        lcg_state = 32'h048d2b07;
        hold_delay = 1;
        word_limit = 0;
        words_seen = 0;
        eop_seen = 0;
        checks = 0;
        errors = 0;
        timeouts = 0;

        repeat (3) @(negedge clock);
        reset <= 1'b0;
        check_idle_outputs(4'b1111);

        // Single transfers, one of each direction
        write_mode(MODE_SINGLE, TYPE_WRITE, 1);
        write_mode(MODE_SINGLE, TYPE_READ, 2);
        run_transfer(1, 1, 0);
        run_transfer(2, 1, 0);

        // Two requests at once, channel 1 goes first
        expected_channel <= 1;
        word_limit <= 0;
        words_seen <= 0;
        request_i <= 4'b0110;
        @(negedge clock);
        wait_words(1);
        request_i[1] <= 1'b0;
        wait_signal("hold_request_o", 1'b0);
        expected_channel <= 2;
        @(negedge clock);
        wait_words(2);
        request_i[2] <= 1'b0;
        wait_signal("hold_request_o", 1'b0);
        check_value("next_word_o pulses", words_seen, 2);

        // Cascade holds the acknowledge until the request drops
        write_mode(MODE_CASCADE, TYPE_WRITE, 0);
        expected_channel <= 0;
        words_seen <= 0;
        request_i[0] <= 1'b1;
        @(negedge clock);
        wait_signal("dack_o[0]", 1'b0);
        repeat (4) @(negedge clock);
        check_value("dack_o", dack_o, 4'b1110);
        check_value("address_enable_o", address_enable_o, 0);
        request_i[0] <= 1'b0;
        wait_signal("hold_request_o", 1'b0);
        check_value("next_word_o pulses", words_seen, 0);

        // Block of four words ending on terminal count
        write_mode(MODE_BLOCK, TYPE_READ, 2);
        run_transfer(2, 4, 4);
        check_value("end_of_process_o pulses", eop_seen, 1);
        check_value("tc_status_o", tc_status_o, 4'b0100);
        read_status_i <= 1'b1;
        @(negedge clock);
        check_value("tc_status_o", tc_status_o, 4'b0100);
        read_status_i <= 1'b0;
        @(negedge clock);
        check_value("tc_status_o", tc_status_o, 4'b0000);

        // Demand transfer cut short by end_of_process_i in the third word
        write_mode(MODE_DEMAND, TYPE_WRITE, 1);
        expected_channel <= 1;
        word_limit <= 0;
        words_seen <= 0;
        eop_seen <= 0;
        request_i[1] <= 1'b1;
        @(negedge clock);
        wait_words(2);
        end_of_process_i <= 1'b1;
        @(negedge clock);
        end_of_process_i <= 1'b0;
        wait_signal("hold_request_o", 1'b0);
        request_i[1] <= 1'b0;
        @(negedge clock);
        check_value("next_word_o pulses", words_seen, 3);
        check_value("end_of_process_o pulses", eop_seen, 0);
        check_value("tc_status_o", tc_status_o, 4'b0010);

        // Verify moves no data
        write_mode(MODE_SINGLE, TYPE_VERIFY, 3);
        run_transfer(3, 1, 0);

        // Active high acknowledge, channel 2 is still a block ending on its first word
        write_command(1'b1);
        run_transfer(2, 1, 1);
        check_value("dack_o", dack_o, 4'b0000);

        // Master clear brings back the reset values
        master_clear_i <= 1'b1;
        @(negedge clock);
        master_clear_i <= 1'b0;
        command_word <= '0;
        for (int i = 0; i < `DMA_CHANNELS; i++)
            mode_words[i] <= '0;
        check_idle_outputs(4'b1111);

        @(negedge clock);
        $display("Checks: %0d, errors: %0d, timeouts: %0d, assertion failures: %0d",
                 checks, errors, timeouts, UUT.u_chk.failures);
        if (errors == 0 && timeouts == 0 && UUT.u_chk.failures == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+hdl
hdl/dma_pkg.sv
hdl/dma_mode_registers.sv
hdl/dma_cycle_fsm.sv
hdl/dma_bus_control.sv
hdl/dma_end_of_process.sv
hdl/dma_timing_control.sv
test/dma_timing_control_chk.sv
test/dma_timing_control_tb.sv
